// File: source/alu_pkg.sv
package alu_pkg;

	// Datapath width for operands and results
	localparam int ALU_W = 32;

	// Opcode field width
	localparam int ALU_OP_W = 3;

	// Operation codes
	// 100 and 110 are reserved and left unnamed
	// They fall to the default arm of the core and return zeros
	typedef enum logic [ALU_OP_W-1:0] {
		OP_ADD = 3'b000, // a + b
		OP_SUB = 3'b001, // a - b via a + ~b + 1
		OP_MUL = 3'b010, // Low word of unsigned product
		OP_SLL = 3'b011, // Logical shift left by b
		OP_XOR = 3'b101, // Bitwise exclusive-or
		OP_SRL = 3'b111  // Logical shift right by b
	} alu_op_t;

	// Condition flags with n in the top bit
	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry out, or no borrow on subtract
		logic v; // Signed overflow
	} alu_flags_t;

	// Request payload of 68 bits
	typedef struct packed {
		alu_op_t          op;
		logic [ALU_W-1:0] a;
		logic [ALU_W-1:0] b;
		logic             set_flags; // Commit flags on delivery
	} alu_req_t;

	// Response payload of 37 bits
	typedef struct packed {
		logic [ALU_W-1:0] result;
		alu_flags_t       flags;
		logic             set_flags; // Copied from the request
	} alu_rsp_t;

endpackage

// File: source/alu_adder.sv
`timescale 1ns/1ps

// Shared by the add and subtract paths of the core
module alu_adder import alu_pkg::*; (
	input  logic [ALU_W-1:0] a,
	input  logic [ALU_W-1:0] b,
	input  logic             carry_in,
	input  logic             invert_b, // Set for subtract
	output logic [ALU_W-1:0] sum,
	output alu_flags_t       flags
);

	logic [ALU_W-1:0] b_eff; // b after optional inversion
	logic             carry_out;
	logic             a_msb;
	logic             b_msb;
	logic             s_msb;

	assign b_eff = invert_b ? ~b : b;

	// One wide add picks up the carry out of the top bit
	assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{ALU_W{1'b0}}, carry_in};

	// Sign bits for overflow
	assign a_msb = a[ALU_W-1];
	assign b_msb = b_eff[ALU_W-1];
	assign s_msb = sum[ALU_W-1];

	// Same-sign operands with a sum of the other sign
	assign flags.v = (a_msb == b_msb) && (s_msb != a_msb);
	assign flags.c = carry_out;
	assign flags.n = s_msb;
	assign flags.z = (sum == '0); // All bits clear

endmodule

// File: source/alu_core.sv
`timescale 1ns/1ps

// Purely combinational, no clock in here
module alu_core import alu_pkg::*; (
	input  alu_req_t req,
	output alu_rsp_t rsp
);

	logic [ALU_W-1:0]   add_sum;
	logic [ALU_W-1:0]   sub_sum;
	alu_flags_t         add_flags;
	alu_flags_t         sub_flags;
	logic [2*ALU_W-1:0] prod;     // Full unsigned product
	logic               prod_hi;  // High word nonzero
	alu_flags_t         mul_flags;
	logic [ALU_W-1:0]   sll_res;
	logic [ALU_W-1:0]   srl_res;
	logic [ALU_W-1:0]   xor_res;
	logic               rsv_op;   // Opcode 100 or 110

	// Plain add
	alu_adder u_add (
		.a        (req.a),
		.b        (req.b),
		.carry_in (1'b0),
		.invert_b (1'b0),
		.sum      (add_sum),
		.flags    (add_flags)
	);

	// a + ~b + 1 for subtract
	alu_adder u_sub (
		.a        (req.a),
		.b        (req.b),
		.carry_in (1'b1),
		.invert_b (1'b1),
		.sum      (sub_sum),
		.flags    (sub_flags)
	);

	// Multiply flags come from the 64-bit product
	assign prod    = req.a * req.b;
	assign prod_hi = |prod[2*ALU_W-1:ALU_W];

	assign mul_flags.n = prod[ALU_W-1];
	assign mul_flags.z = (prod[ALU_W-1:0] == '0);
	assign mul_flags.c = prod_hi; // Lost high bits
	assign mul_flags.v = prod_hi;

	// Whole b is the shift amount so 32 and up gives zero
	assign sll_res = req.a << req.b;
	assign srl_res = req.a >> req.b;
	assign xor_res = req.a ^ req.b;

	// Reserved codes are whatever is not a named op
	assign rsv_op = !(req.op inside {OP_ADD, OP_SUB, OP_MUL, OP_SLL, OP_XOR, OP_SRL});

	// Result and flag select
	always_comb begin
		rsp.set_flags = req.set_flags; // Passes straight through
		case (req.op)
			OP_ADD: begin
				rsp.result = add_sum;
				rsp.flags  = add_flags;
			end
			OP_SUB: begin
				rsp.result = sub_sum;
				rsp.flags  = sub_flags;
			end
			OP_MUL: begin
				rsp.result = prod[ALU_W-1:0];
				rsp.flags  = mul_flags;
			end
			OP_SLL: begin
				rsp.result = sll_res;
				rsp.flags  = '0; // Logic ops leave flags clear
			end
			OP_XOR: begin
				rsp.result = xor_res;
				rsp.flags  = '0;
			end
			OP_SRL: begin
				rsp.result = srl_res;
				rsp.flags  = '0;
			end
			default: begin
				rsp.result = '0; // Reserved
				rsp.flags  = '0;
			end
		endcase
	end

	// Reserved opcodes must give all zeros out of the whole select
	always_comb begin
		if (rsv_op) begin
			a_rsv_zero: assert final (rsp.result == '0 && rsp.flags == '0)
				else $error("reserved op %b gave nonzero output", req.op);
		end
	end

endmodule

// File: source/pipe_stage.sv
`timescale 1ns/1ps

// Single-entry register slice with a valid/ready handshake
module pipe_stage #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	logic load; // Upstream transfer this cycle

	// Room when empty or when the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	// Valid flag
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid; // Refill or drain
		end
	end

	// Payload has no reset
	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

	// Held data must not move under back-pressure
	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> $stable(out_data))
		else $error("out_data changed while stalled");

	// Once offered, an item stays offered until taken
	a_valid_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped before accept");

endmodule

// File: source/alu_flag_reg.sv
`timescale 1ns/1ps

// Architectural NZCV state
module alu_flag_reg import alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       rsp_valid,
	input  logic       rsp_ready,
	input  alu_rsp_t   rsp,
	output alu_flags_t flags
);

	logic delivered; // Response handshake
	logic update;    // Handshake with set_flags

	assign delivered = rsp_valid && rsp_ready;
	assign update    = delivered && rsp.set_flags;

	// Loads only on a delivered flag-setting result
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (update) begin
			flags <= rsp.flags;
		end
	end

	// Any change traces back to an update one edge earlier
	a_flags_change: assert property (@(posedge clk) disable iff (rst)
		!$stable(flags) |-> $past(update))
		else $error("flags changed without a flag-setting response");

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps

// Request slice, core, response slice, flag register
module alu_unit import alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       req_valid,
	output logic       req_ready,
	input  alu_req_t   req,
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output alu_rsp_t   rsp,
	output alu_flags_t flags
);

	alu_req_t core_req;  // Registered request into the core
	alu_rsp_t core_rsp;  // Combinational result
	logic     mid_valid; // Between the two stages
	logic     mid_ready;

	// Input slice
	pipe_stage #(
		.T (alu_req_t)
	) u_req_stage (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (req),
		.out_valid (mid_valid),
		.out_ready (mid_ready), // Straight from the output slice
		.out_data  (core_req)
	);

	alu_core u_core (
		.req (core_req),
		.rsp (core_rsp)
	);

	// Output slice
	pipe_stage #(
		.T (alu_rsp_t)
	) u_rsp_stage (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (mid_valid),
		.in_ready  (mid_ready),
		.in_data   (core_rsp),
		.out_valid (rsp_valid),
		.out_ready (rsp_ready),
		.out_data  (rsp)
	);

	// Watches the external response handshake
	alu_flag_reg u_flag_reg (
		.clk       (clk),
		.rst       (rst),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.flags     (flags)
	);

endmodule

// File: dv/alu_unit_tb.sv
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*; ();

	localparam int          N_TESTS     = 400;              // Requests over the whole run
	localparam int unsigned CYCLE_LIMIT = N_TESTS * 4 + 50; // Timeout bound
	localparam logic [31:0] SEED        = 32'd74980;

	typedef struct packed {
		alu_rsp_t    rsp; // Model response
		int unsigned cyc; // Cycle of acceptance
	} exp_item_t;

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic        req_ready;
	alu_req_t    req;
	logic        rsp_valid;
	logic        rsp_ready;
	alu_rsp_t    rsp;
	alu_flags_t  flags;

	exp_item_t   exp_q[$];    // Scoreboard, oldest first
	exp_item_t   cur_item;
	alu_flags_t  model_flags; // Expected flag register
	alu_rsp_t    held_rsp;    // rsp seen on a stalled cycle
	logic        was_stalled;
	logic        stalls_on;   // Random rsp_ready enable
	logic [31:0] lfsr_req;    // Stimulus stream
	logic [31:0] lfsr_stall;  // Back-pressure stream
	logic [31:0] stall_bits;
	int unsigned cycle;
	int          n_sent;
	int          n_accepted;
	int          n_done;

	alu_unit u_dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.flags     (flags)
	);

	always #10 clk = ~clk; // 20 ns period

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_step(inout logic [31:0] st);
		logic fb;
		fb = st[31] ^ st[21] ^ st[1] ^ st[0];
		st = {st[30:0], fb};
		return fb;
	endfunction

	// One step per bit with the newest bit in bit 0
	function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step(st)};
		end
		return v;
	endfunction

	// Expected response straight from the flag rules
	function automatic alu_rsp_t model_rsp(input alu_req_t r);
		alu_rsp_t           m;
		longint             sa;
		longint             sb;
		longint             sr;  // Exact signed result
		logic [2*ALU_W-1:0] p;
		m           = '0;
		m.set_flags = r.set_flags;
		sa          = longint'($signed(r.a));
		sb          = longint'($signed(r.b));
		case (r.op)
			OP_ADD: begin
				m.result  = r.a + r.b;
				m.flags.c = (m.result < r.a); // Wrapped means carry
				sr        = sa + sb;
				m.flags.v = (sr != longint'($signed(m.result)));
			end
			OP_SUB: begin
				m.result  = r.a - r.b;
				m.flags.c = (r.a >= r.b); // No borrow
				sr        = sa - sb;
				m.flags.v = (sr != longint'($signed(m.result)));
			end
			OP_MUL: begin
				p         = {{ALU_W{1'b0}}, r.a} * {{ALU_W{1'b0}}, r.b};
				m.result  = p[ALU_W-1:0];
				m.flags.c = |p[2*ALU_W-1:ALU_W];
				m.flags.v = |p[2*ALU_W-1:ALU_W];
			end
			OP_SLL: m.result = (r.b >= ALU_W) ? '0 : r.a << r.b[4:0];
			OP_SRL: m.result = (r.b >= ALU_W) ? '0 : r.a >> r.b[4:0];
			OP_XOR: m.result = r.a ^ r.b;
			default: m.result = '0; // Reserved
		endcase
		if (r.op inside {OP_ADD, OP_SUB, OP_MUL}) begin
			m.flags.n = m.result[ALU_W-1];
			m.flags.z = (m.result == '0);
		end
		return m;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	// Holds the request until the edge that takes it
	task automatic send_req(input alu_req_t r);
		logic taken;
		taken     = 1'b0;
		req       = r;
		req_valid = 1'b1;
		while (!taken) begin
			@(posedge clk);
			taken = req_ready;
			#1;
		end
		req_valid = 1'b0;
		n_sent++;
	endtask

	task automatic send_op(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
			input logic sf);
		alu_req_t r;
		r.op        = op;
		r.a         = a;
		r.b         = b;
		r.set_flags = sf;
		send_req(r);
	endtask

	task automatic send_random();
		alu_req_t    r;
		logic [31:0] bits;
		bits   = rand_bits(lfsr_req, 3);
		r.op   = alu_op_t'(bits[2:0]); // Reserved codes included
		r.a    = rand_bits(lfsr_req, 32);
		bits   = rand_bits(lfsr_req, 1);
		if (bits[0]) begin
			r.b = rand_bits(lfsr_req, 6); // Small b, shift amounts around ALU_W
		end else begin
			r.b = rand_bits(lfsr_req, 32);
		end
		bits        = rand_bits(lfsr_req, 1);
		r.set_flags = bits[0];
		send_req(r);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		#1;
	endtask

	// Back-pressure stalls half the cycles once enabled
	always @(posedge clk) begin
		#1;
		if (stalls_on) begin
			stall_bits = rand_bits(lfsr_stall, 1);
			rsp_ready  = stall_bits[0];
		end else begin
			rsp_ready = 1'b1;
		end
	end

	// Monitor, scoreboard and timeout on pre-edge values
	always @(posedge clk) begin
		cycle++;
		if (cycle > CYCLE_LIMIT) begin
			report_error("timeout, responses did not finish within the cycle limit");
		end
		if (!rst) begin
			check_flags("flags", model_flags, flags); // Last committed flags
			if (was_stalled) begin
				check_bit("rsp_valid (stalled)", 1'b1, rsp_valid);
				check_word("rsp.result (stalled)", held_rsp.result, rsp.result);
				check_flags("rsp.flags (stalled)", held_rsp.flags, rsp.flags);
				check_bit("rsp.set_flags (stalled)", held_rsp.set_flags, rsp.set_flags);
			end
			if (req_valid && req_ready) begin
				cur_item.rsp = model_rsp(req);
				cur_item.cyc = cycle;
				exp_q.push_back(cur_item);
				n_accepted++;
			end
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					report_error("response delivered with no request outstanding");
				end
				cur_item = exp_q.pop_front();
				check_word("rsp.result", cur_item.rsp.result, rsp.result);
				check_flags("rsp.flags", cur_item.rsp.flags, rsp.flags);
				check_bit("rsp.set_flags", cur_item.rsp.set_flags, rsp.set_flags);
				if (!stalls_on) begin
					check_word("latency", 32'd2, cycle - cur_item.cyc);
				end
				if (cur_item.rsp.set_flags) begin
					model_flags = cur_item.rsp.flags; // Visible next cycle
				end
				n_done++;
			end
			was_stalled = rsp_valid && !rsp_ready;
			held_rsp    = rsp;
		end
	end

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		req_valid   = 1'b0;
		req         = '0;
		rsp_ready   = 1'b1;
		stalls_on   = 1'b0;
		lfsr_req    = SEED;
		lfsr_stall  = SEED;
		model_flags = '0;
		held_rsp    = '0;
		was_stalled = 1'b0;
		cycle       = 0;
		n_sent      = 0;
		n_accepted  = 0;
		n_done      = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		check_bit("rsp_valid after reset", 1'b0, rsp_valid);
		check_bit("req_ready after reset", 1'b1, req_ready);
		check_flags("flags after reset", '0, flags);
		// Add with carry and zero, then overflow both ways
		send_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001, 1'b1);
		send_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
		send_op(OP_ADD, 32'h8000_0000, 32'h8000_0000, 1'b0);
		send_op(OP_ADD, 32'h0000_0001, 32'h0000_0002, 1'b1);
		// Subtract for zero, borrow and overflow both ways
		send_op(OP_SUB, 32'h0000_0005, 32'h0000_0005, 1'b1);
		send_op(OP_SUB, 32'h0000_0003, 32'h0000_0005, 1'b1);
		send_op(OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b0);
		send_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
		// Multiply with high word zero and nonzero
		send_op(OP_MUL, 32'h0001_0000, 32'h0001_0000, 1'b1);
		send_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
		send_op(OP_MUL, 32'h0000_ffff, 32'h0000_ffff, 1'b1);
		send_op(OP_MUL, 32'h0000_0003, 32'h0000_0005, 1'b0);
		// Logic ops clear flags
		send_op(OP_XOR, 32'hdead_beef, 32'hffff_0000, 1'b1);
		send_op(OP_SLL, 32'h0000_0003, 32'd31, 1'b1);
		send_op(OP_SLL, 32'hffff_ffff, 32'd32, 1'b0);
		send_op(OP_SLL, 32'hffff_ffff, 32'd100, 1'b1);
		send_op(OP_SRL, 32'h8000_0001, 32'd31, 1'b1);
		send_op(OP_SRL, 32'hffff_ffff, 32'd32, 1'b1);
		send_op(OP_SRL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		send_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001, 1'b1); // Flags set before reserved
		send_op(alu_op_t'(3'b100), 32'h1234_5678, 32'h8765_4321, 1'b1);
		send_op(alu_op_t'(3'b110), 32'hffff_ffff, 32'h0000_0001, 1'b1);
		// Random at full throughput
		while (n_sent < N_TESTS / 2) begin
			send_random();
		end
		wait_drain();
		stalls_on = 1'b1;
		// Random under back-pressure
		while (n_sent < N_TESTS) begin
			send_random();
		end
		wait_drain();
		repeat (3) @(posedge clk);
		#1;
		if (exp_q.size() == 0 && n_accepted == N_TESTS && n_done == n_accepted) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_error("request and response counts do not match at the end of the run");
		end
	end

endmodule

// File: files.f
source/alu_pkg.sv
source/alu_adder.sv
source/alu_core.sv
source/pipe_stage.sv
source/alu_flag_reg.sv
source/alu_unit.sv
dv/alu_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= alu_unit_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the output holds the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
